/* list.f */
design/tile_cfg_pkg.sv
design/tcdm_pkg.sv
design/tcdm_port_if.sv
design/tcdm_bank.sv
design/core_demux.sv
design/remote_req_reg.sv
design/bank_xbar.sv
design/tcdm_tile.sv
tests/tb_tcdm_tile.sv

/* Makefile */
TOP := tb_tcdm_tile

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/tb_tcdm_tile.sv */
// ==================================================
// Testbench for the TCDM tile: stimulus, models,
// response checker and watchdog
// ==================================================
module tb_tcdm_tile;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumCores     = tile_cfg_pkg::NumCoresPerTile;
  localparam int unsigned NumPorts     = 2 * NumCores;
  localparam int unsigned NumWords     = 256;
  localparam int unsigned OpsPerStream = 40;
  // Fill, four stream phases and the final readback
  localparam int unsigned NumOps       = 2 * NumWords + 4 * NumPorts * OpsPerStream;
  localparam logic [1:0]  TileId       = 2'd1;

  logic                                clk_i = 1'b0;
  logic                                rst_ni;
  logic [1:0]                          tile_id_i;
  logic [NumCores-1:0]                 core_req_i;
  tcdm_pkg::addr_t [NumCores-1:0]      core_addr_i;
  logic [NumCores-1:0]                 core_wen_i;
  tcdm_pkg::data_t [NumCores-1:0]      core_wdata_i;
  tcdm_pkg::be_t [NumCores-1:0]        core_be_i;
  logic [NumCores-1:0]                 core_gnt_o;
  logic [NumCores-1:0]                 core_vld_o;
  tcdm_pkg::data_t [NumCores-1:0]      core_rdata_o;
  logic [NumCores-1:0]                 tcdm_master_req_o;
  tcdm_pkg::addr_t [NumCores-1:0]      tcdm_master_addr_o;
  logic [NumCores-1:0]                 tcdm_master_wen_o;
  tcdm_pkg::data_t [NumCores-1:0]      tcdm_master_wdata_o;
  tcdm_pkg::be_t [NumCores-1:0]        tcdm_master_be_o;
  logic [NumCores-1:0]                 tcdm_master_gnt_i;
  logic [NumCores-1:0]                 tcdm_master_vld_i;
  tcdm_pkg::data_t [NumCores-1:0]      tcdm_master_rdata_i;
  logic [NumCores-1:0]                 mem_req_i;
  tcdm_pkg::core_addr_t [NumCores-1:0] mem_ret_addr_i;
  logic [NumCores-1:0]                 mem_gnt_o;
  tcdm_pkg::tile_addr_t [NumCores-1:0] mem_addr_i;
  logic [NumCores-1:0]                 mem_wen_i;
  tcdm_pkg::data_t [NumCores-1:0]      mem_wdata_i;
  tcdm_pkg::be_t [NumCores-1:0]        mem_be_i;
  logic [NumCores-1:0]                 mem_vld_o;
  tcdm_pkg::core_addr_t [NumCores-1:0] mem_resp_addr_o;
  tcdm_pkg::data_t [NumCores-1:0]      mem_rdata_o;

  // Ports 0..1 are cores, 2..3 are incoming remote ports
  tcdm_pkg::data_t exp_q [NumPorts][$];
  int unsigned     due_q [NumPorts][$];
  // Outgoing requests as {addr, wen, wdata, be}
  logic [68:0]     out_q [NumCores][$];
  tcdm_pkg::data_t rsp_q [NumCores][$];
  int unsigned     rsp_due_q [NumCores][$];
  tcdm_pkg::data_t shadow [NumWords];
  tcdm_pkg::data_t rem_shadow [1024];
  tcdm_pkg::data_t net_mem [1024];

  logic [31:0]          stim_state = 32'h37df;
  logic [31:0]          net_state = 32'h37df;
  int unsigned          cycle = 0;
  logic                 rst_q = 1'b0;
  tcdm_pkg::core_addr_t [NumCores-1:0] prev_ret = '0;

  tcdm_tile UUT (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic tcdm_pkg::data_t fill_word(input logic [9:0] idx);
    return {idx[7:0], ~idx[9:2], 6'h2b, idx};
  endfunction

  // Core address, LSB first: byte, bank, tile, row
  function automatic tcdm_pkg::addr_t make_addr(input logic [1:0] tile, input logic [1:0] bank,
                                                input logic [5:0] row);
    return {20'd0, row, tile, bank, 2'b00};
  endfunction

  // Network address, LSB first: byte, core, tile, bank, row
  function automatic tcdm_pkg::addr_t swizzle(input tcdm_pkg::addr_t a, input logic core);
    return (a & 32'h3) | (32'(core) << 2) | (32'(a[5:4]) << 3) | (32'(a[3:2]) << 5)
           | (32'(a[11:6]) << 7);
  endfunction

  // Reference for a word after a byte-enabled write
  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old,
                                                  input tcdm_pkg::data_t wdata,
                                                  input tcdm_pkg::be_t be);
    tcdm_pkg::data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    check_value("core_gnt_o", '0, 32'(core_gnt_o));
    check_value("core_vld_o", '0, 32'(core_vld_o));
    check_value("tcdm_master_req_o", '0, 32'(tcdm_master_req_o));
    check_value("mem_vld_o", '0, 32'(mem_vld_o));
    check_value("mem_resp_addr_o", '0, 32'(mem_resp_addr_o));
  endtask

  // Model update in grant order, one grant per bank and cycle
  function automatic void record_grant(input int p, input logic wen, input tcdm_pkg::addr_t addr,
                                       input tcdm_pkg::data_t wdata, input tcdm_pkg::be_t be);
    logic [7:0] widx;
    logic [9:0] ridx;
    widx = {addr[11:6], addr[3:2]};
    ridx = addr[11:2];
    if (p < int'(NumCores) && addr[5:4] != TileId) begin
      out_q[p].push_back({swizzle(addr, p[0]), wen, wdata, be});
      if (wen) begin
        rem_shadow[ridx] = merge_bytes(rem_shadow[ridx], wdata, be);
      end else begin
        exp_q[p].push_back(rem_shadow[ridx]);
        due_q[p].push_back(0);
      end
    end else if (wen) begin
      shadow[widx] = merge_bytes(shadow[widx], wdata, be);
    end else begin
      exp_q[p].push_back(shadow[widx]);
      due_q[p].push_back(cycle + 1);
    end
  endfunction

  // Called 2 ns after a rising edge, returns at the same phase
  task automatic do_op(input int p, input logic wen, input tcdm_pkg::addr_t addr,
                       input tcdm_pkg::data_t wdata, input tcdm_pkg::be_t be);
    logic granted;
    int   m;
    granted = 1'b0;
    m = p - int'(NumCores);
    if (p < int'(NumCores)) begin
      core_req_i[p]   = 1'b1;
      core_addr_i[p]  = addr;
      core_wen_i[p]   = wen;
      core_wdata_i[p] = wdata;
      core_be_i[p]    = be;
    end else begin
      mem_req_i[m]   = 1'b1;
      mem_addr_i[m]  = {addr[11:6], addr[3:2]};
      mem_wen_i[m]   = wen;
      mem_wdata_i[m] = wdata;
      mem_be_i[m]    = be;
    end
    while (!granted) begin
      @(negedge clk_i);
      granted = (p < int'(NumCores)) ? core_gnt_o[p] : mem_gnt_o[m];
      if (granted) begin
        record_grant(p, wen, addr, wdata, be);
      end
      @(posedge clk_i);
      #2;
    end
    if (p < int'(NumCores)) begin
      core_req_i[p] = 1'b0;
    end else begin
      mem_req_i[m] = 1'b0;
    end
  endtask

  // Mode 0 local, 1 remote, 2 mixed, 3 one bank under contention
  task automatic run_stream(input int p, input int mode);
    logic [31:0] r;
    logic [1:0]  tile;
    logic [1:0]  bank;
    logic [5:0]  row;
    for (int n = 0; n < int'(OpsPerStream); n++) begin
      stim_state = lcg(stim_state);
      r = stim_state;
      tile = TileId;
      if (p < int'(NumCores) && (mode == 1 || (mode == 2 && r[20]))) begin
        // Each core owns its remote tiles
        tile = (p == 0) ? 2'd0 : {1'b1, r[21]};
      end
      bank = (mode == 3) ? 2'd0 : r[23:22];
      row = (mode == 3) ? {3'd0, r[26:24]} : r[29:24];
      stim_state = lcg(stim_state);
      do_op(p, r[16], make_addr(tile, bank, row), stim_state, r[11:8]);
      if (r[30]) begin
        @(posedge clk_i);
        #2;
      end
    end
  endtask

  function automatic int pending_ops();
    int n;
    n = 0;
    for (int p = 0; p < int'(NumPorts); p++) begin
      n += exp_q[p].size();
    end
    for (int c = 0; c < int'(NumCores); c++) begin
      n += out_q[c].size();
    end
    return n;
  endfunction

  // Network side: back-pressure, read responses, return addresses
  initial begin : network
    tcdm_master_gnt_i   = '0;
    tcdm_master_vld_i   = '0;
    tcdm_master_rdata_i = '0;
    mem_ret_addr_i      = '0;
    forever begin
      @(posedge clk_i);
      #2;
      net_state = lcg(net_state);
      mem_ret_addr_i = net_state[21:16];
      for (int c = 0; c < int'(NumCores); c++) begin
        tcdm_master_gnt_i[c] = net_state[24+c];
        tcdm_master_vld_i[c] = 1'b0;
        if (rsp_q[c].size() != 0 && rsp_due_q[c][0] <= cycle) begin
          tcdm_master_vld_i[c]   = 1'b1;
          tcdm_master_rdata_i[c] = rsp_q[c].pop_front();
          void'(rsp_due_q[c].pop_front());
        end
      end
    end
  end

  always @(negedge clk_i) begin : compare
    logic            vld;
    tcdm_pkg::data_t rdata;
    tcdm_pkg::data_t exp_word;
    int unsigned     due;
    logic [68:0]     exp_out;
    tcdm_pkg::addr_t maddr;
    logic [9:0]      nidx;
    if (rst_q) begin
      for (int p = 0; p < int'(NumPorts); p++) begin
        vld = (p < int'(NumCores)) ? core_vld_o[p] : mem_vld_o[p-int'(NumCores)];
        rdata = (p < int'(NumCores)) ? core_rdata_o[p] : mem_rdata_o[p-int'(NumCores)];
        if (vld) begin
          if (exp_q[p].size() == 0) begin
            abort_run($sformatf("Read response on port %0d without a pending read", p));
          end
          exp_word = exp_q[p].pop_front();
          due = due_q[p].pop_front();
          check_value($sformatf("rdata port %0d", p), exp_word, rdata);
          // Bank reads answer exactly one cycle after the grant
          if (due != 0) begin
            check_value($sformatf("vld cycle port %0d", p), due, cycle);
          end
        end
      end
      for (int c = 0; c < int'(NumCores); c++) begin
        check_value($sformatf("mem_resp_addr_o[%0d]", c), 32'(prev_ret[c]),
                    32'(mem_resp_addr_o[c]));
        if (tcdm_master_req_o[c] && tcdm_master_gnt_i[c]) begin
          if (out_q[c].size() == 0) begin
            abort_run($sformatf("Outgoing request on core %0d that no core issued", c));
          end
          exp_out = out_q[c].pop_front();
          maddr = tcdm_master_addr_o[c];
          check_value($sformatf("tcdm_master_addr_o[%0d]", c), exp_out[68:37], maddr);
          check_value($sformatf("tcdm_master_wen_o[%0d]", c), 32'(exp_out[36]),
                      32'(tcdm_master_wen_o[c]));
          check_value($sformatf("tcdm_master_wdata_o[%0d]", c), exp_out[35:4],
                      tcdm_master_wdata_o[c]);
          check_value($sformatf("tcdm_master_be_o[%0d]", c), 32'(exp_out[3:0]),
                      32'(tcdm_master_be_o[c]));
          nidx = {maddr[12:7], maddr[4:3], maddr[6:5]};
          if (tcdm_master_wen_o[c]) begin
            net_mem[nidx] = merge_bytes(net_mem[nidx], tcdm_master_wdata_o[c],
                                        tcdm_master_be_o[c]);
          end else begin
            due = cycle + 1 + 32'(net_state[9:8]);
            if (rsp_due_q[c].size() != 0 && due <= rsp_due_q[c][$]) begin
              due = rsp_due_q[c][$] + 1;
            end
            rsp_q[c].push_back(net_mem[nidx]);
            rsp_due_q[c].push_back(due);
          end
        end
      end
    end
    rst_q = rst_ni;
    prev_ret = mem_ret_addr_i;
  end

  initial begin : watchdog
    repeat (NumOps * 50) @(posedge clk_i);
    abort_run("Timeout: the operations did not complete in time");
  end

  initial begin : stimulus
    tile_id_i    = TileId;
    rst_ni       = 1'b0;
    core_req_i   = '0;
    core_addr_i  = '0;
    core_wen_i   = '0;
    core_wdata_i = '0;
    core_be_i    = '0;
    mem_req_i    = '0;
    mem_addr_i   = '0;
    mem_wen_i    = '0;
    mem_wdata_i  = '0;
    mem_be_i     = '0;
    for (int i = 0; i < 1024; i++) begin
      rem_shadow[i] = fill_word(10'(i));
      net_mem[i]    = fill_word(10'(i));
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_idle();
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();
    @(posedge clk_i);
    #2;
    // Full-word fill, the banks start undefined
    for (int i = 0; i < int'(NumWords); i++) begin
      do_op(NumCores, 1'b1, make_addr(TileId, i[1:0], i[7:2]), fill_word(10'(i) ^ 10'h2c7),
            4'hf);
    end
    for (int mode = 0; mode < 4; mode++) begin
      fork
        run_stream(0, mode);
        run_stream(1, mode);
        run_stream(2, mode);
        run_stream(3, mode);
      join
    end
    // Readback of every bank word
    for (int i = 0; i < int'(NumWords); i++) begin
      do_op(NumCores + 1, 1'b0, make_addr(TileId, i[1:0], i[7:2]), '0, '0);
    end
    while (pending_ops() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    if (tcdm_master_req_o == '0 && core_vld_o == '0 && mem_vld_o == '0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Outputs still active after all operations completed");
    end
  end

endmodule

/* design/tcdm_tile.sv */
// ==================================================
// TCDM tile top: demuxes, remote registers, crossbar
// ==================================================
module tcdm_tile #(
  localparam int unsigned NumCores  = tile_cfg_pkg::NumCoresPerTile,
  localparam int unsigned NumInputs = 2 * NumCores
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [tile_cfg_pkg::TileIdxWidth-1:0] tile_id_i,
  // Core data ports
  input  logic [NumCores-1:0]                   core_req_i,
  input  tcdm_pkg::addr_t [NumCores-1:0]        core_addr_i,
  input  logic [NumCores-1:0]                   core_wen_i,
  input  tcdm_pkg::data_t [NumCores-1:0]        core_wdata_i,
  input  tcdm_pkg::be_t [NumCores-1:0]          core_be_i,
  output logic [NumCores-1:0]                   core_gnt_o,
  output logic [NumCores-1:0]                   core_vld_o,
  output tcdm_pkg::data_t [NumCores-1:0]        core_rdata_o,
  // Outgoing remote requests
  output logic [NumCores-1:0]                   tcdm_master_req_o,
  output tcdm_pkg::addr_t [NumCores-1:0]        tcdm_master_addr_o,
  output logic [NumCores-1:0]                   tcdm_master_wen_o,
  output tcdm_pkg::data_t [NumCores-1:0]        tcdm_master_wdata_o,
  output tcdm_pkg::be_t [NumCores-1:0]          tcdm_master_be_o,
  input  logic [NumCores-1:0]                   tcdm_master_gnt_i,
  input  logic [NumCores-1:0]                   tcdm_master_vld_i,
  input  tcdm_pkg::data_t [NumCores-1:0]        tcdm_master_rdata_i,
  // Incoming requests from other tiles
  input  logic [NumCores-1:0]                   mem_req_i,
  input  tcdm_pkg::core_addr_t [NumCores-1:0]   mem_ret_addr_i,
  output logic [NumCores-1:0]                   mem_gnt_o,
  input  tcdm_pkg::tile_addr_t [NumCores-1:0]   mem_addr_i,
  input  logic [NumCores-1:0]                   mem_wen_i,
  input  tcdm_pkg::data_t [NumCores-1:0]        mem_wdata_i,
  input  tcdm_pkg::be_t [NumCores-1:0]          mem_be_i,
  output logic [NumCores-1:0]                   mem_vld_o,
  output tcdm_pkg::core_addr_t [NumCores-1:0]   mem_resp_addr_o,
  output tcdm_pkg::data_t [NumCores-1:0]        mem_rdata_o
);

  tcdm_port_if local_if [NumCores] ();
  tcdm_port_if remote_if [NumCores] ();

  tcdm_pkg::addr_t [NumCores-1:0] mem_addr;

  for (genvar c = 0; c < NumCores; c++) begin : gen_cores
    core_demux i_core_demux (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .tile_id_i    (tile_id_i),
      .core_req_i   (core_req_i[c]),
      .core_addr_i  (core_addr_i[c]),
      .core_wen_i   (core_wen_i[c]),
      .core_wdata_i (core_wdata_i[c]),
      .core_be_i    (core_be_i[c]),
      .core_gnt_o   (core_gnt_o[c]),
      .core_vld_o   (core_vld_o[c]),
      .core_rdata_o (core_rdata_o[c]),
      .local_o      (local_if[c]),
      .remote_o     (remote_if[c])
    );

    remote_req_reg #(
      .CoreIdx (c)
    ) i_remote_req_reg (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .req_i               (remote_if[c]),
      .tcdm_master_req_o   (tcdm_master_req_o[c]),
      .tcdm_master_addr_o  (tcdm_master_addr_o[c]),
      .tcdm_master_wen_o   (tcdm_master_wen_o[c]),
      .tcdm_master_wdata_o (tcdm_master_wdata_o[c]),
      .tcdm_master_be_o    (tcdm_master_be_o[c]),
      .tcdm_master_gnt_i   (tcdm_master_gnt_i[c]),
      .tcdm_master_vld_i   (tcdm_master_vld_i[c]),
      .tcdm_master_rdata_i (tcdm_master_rdata_i[c])
    );

    // Word address back to a byte address
    assign mem_addr[c] = tcdm_pkg::addr_t'({mem_addr_i[c], {tile_cfg_pkg::ByteOffset{1'b0}}});
  end

  bank_xbar #(
    .NumInputs (NumInputs)
  ) i_bank_xbar (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .local_i     (local_if),
    .mem_req_i   (mem_req_i),
    .mem_addr_i  (mem_addr),
    .mem_wen_i   (mem_wen_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_be_i    (mem_be_i),
    .mem_gnt_o   (mem_gnt_o),
    .mem_vld_o   (mem_vld_o),
    .mem_rdata_o (mem_rdata_o)
  );

  // Return address follows the one-cycle bank latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_resp_addr_o <= '0;
    end else begin
      mem_resp_addr_o <= mem_ret_addr_i;
    end
  end

endmodule

/* design/bank_xbar.sv */
// ==================================================
// Round-robin crossbar onto the banks
// ==================================================
module bank_xbar #(
  parameter int unsigned NumInputs = 4,
  localparam int unsigned NumLocal = tile_cfg_pkg::NumCoresPerTile,
  localparam int unsigned NumMem   = NumInputs - NumLocal
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  tcdm_port_if.target                  local_i [NumLocal],
  input  logic [NumMem-1:0]            mem_req_i,
  input  tcdm_pkg::addr_t [NumMem-1:0] mem_addr_i,
  input  logic [NumMem-1:0]            mem_wen_i,
  input  tcdm_pkg::data_t [NumMem-1:0] mem_wdata_i,
  input  tcdm_pkg::be_t [NumMem-1:0]   mem_be_i,
  output logic [NumMem-1:0]            mem_gnt_o,
  output logic [NumMem-1:0]            mem_vld_o,
  output tcdm_pkg::data_t [NumMem-1:0] mem_rdata_o
);

  localparam int unsigned NumBanks = tile_cfg_pkg::NumBanksPerTile;
  localparam int unsigned IdxW     = (NumInputs > 1) ? $clog2(NumInputs) : 1;
  localparam int unsigned BankW    = tile_cfg_pkg::BankIdxWidth;
  localparam int unsigned BankLsb  = tile_cfg_pkg::BankLsb;
  // Tile field is already gone here
  localparam int unsigned RowLsb   = BankLsb + BankW;

  logic [NumInputs-1:0]            in_req;
  logic [NumInputs-1:0]            in_wen;
  logic [NumInputs-1:0]            in_gnt;
  logic [NumInputs-1:0]            in_vld;
  tcdm_pkg::addr_t [NumInputs-1:0] in_addr;
  tcdm_pkg::data_t [NumInputs-1:0] in_wdata;
  tcdm_pkg::data_t [NumInputs-1:0] in_rdata;
  tcdm_pkg::be_t [NumInputs-1:0]   in_be;

  logic [NumBanks-1:0]            win_vld;
  logic [NumBanks-1:0][IdxW-1:0]  win_idx;
  logic [NumBanks-1:0][IdxW-1:0]  rr_q;
  logic [NumBanks-1:0]            rd_vld_q;
  logic [NumBanks-1:0][IdxW-1:0]  rd_idx_q;
  tcdm_pkg::data_t [NumBanks-1:0] bank_rdata;

  // Core ports first, then incoming remote ports
  for (genvar i = 0; i < NumLocal; i++) begin : gen_local
    assign in_req[i]      = local_i[i].req;
    assign in_addr[i]     = local_i[i].addr;
    assign in_wen[i]      = local_i[i].wen;
    assign in_wdata[i]    = local_i[i].wdata;
    assign in_be[i]       = local_i[i].be;
    assign local_i[i].gnt   = in_gnt[i];
    assign local_i[i].vld   = in_vld[i];
    assign local_i[i].rdata = in_rdata[i];
  end

  for (genvar j = 0; j < NumMem; j++) begin : gen_mem
    assign in_req[NumLocal+j]   = mem_req_i[j];
    assign in_addr[NumLocal+j]  = mem_addr_i[j];
    assign in_wen[NumLocal+j]   = mem_wen_i[j];
    assign in_wdata[NumLocal+j] = mem_wdata_i[j];
    assign in_be[NumLocal+j]    = mem_be_i[j];
    assign mem_gnt_o[j]   = in_gnt[NumLocal+j];
    assign mem_vld_o[j]   = in_vld[NumLocal+j];
    assign mem_rdata_o[j] = in_rdata[NumLocal+j];
  end

  // First requester at or after the pointer wins the bank
  always_comb begin
    int unsigned idx;
    win_vld = '0;
    win_idx = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int k = 0; k < NumInputs; k++) begin
        idx = rr_q[b] + k;
        if (idx >= NumInputs) begin
          idx = idx - NumInputs;
        end
        if (!win_vld[b] && in_req[idx] && (in_addr[idx][BankLsb +: BankW] == BankW'(b))) begin
          win_vld[b] = 1'b1;
          win_idx[b] = IdxW'(idx);
        end
      end
    end
  end

  always_comb begin
    in_gnt   = '0;
    in_vld   = '0;
    in_rdata = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (win_vld[b]) begin
        in_gnt[win_idx[b]] = 1'b1;
      end
      if (rd_vld_q[b]) begin
        in_vld[rd_idx_q[b]]   = 1'b1;
        in_rdata[rd_idx_q[b]] = bank_rdata[b];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q     <= '0;
      rd_vld_q <= '0;
      rd_idx_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (win_vld[b]) begin
          rr_q[b] <= (win_idx[b] == IdxW'(NumInputs - 1)) ? '0 : win_idx[b] + IdxW'(1);
        end
        rd_vld_q[b] <= win_vld[b] && !in_wen[win_idx[b]];
        rd_idx_q[b] <= win_idx[b];
      end
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    tcdm_bank i_tcdm_bank (
      .clk_i   (clk_i),
      .req_i   (win_vld[b]),
      .we_i    (in_wen[win_idx[b]]),
      .addr_i  (in_addr[win_idx[b]][RowLsb +: tile_cfg_pkg::RowWidth]),
      .wdata_i (in_wdata[win_idx[b]]),
      .be_i    (in_be[win_idx[b]]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

/* design/remote_req_reg.sv */
// ==================================================
// Two-entry register on the outgoing remote port
// ==================================================
module remote_req_reg #(
  parameter int unsigned CoreIdx = 0
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  tcdm_port_if.target     req_i,
  output logic            tcdm_master_req_o,
  output tcdm_pkg::addr_t tcdm_master_addr_o,
  output logic            tcdm_master_wen_o,
  output tcdm_pkg::data_t tcdm_master_wdata_o,
  output tcdm_pkg::be_t   tcdm_master_be_o,
  input  logic            tcdm_master_gnt_i,
  input  logic            tcdm_master_vld_i,
  input  tcdm_pkg::data_t tcdm_master_rdata_i
);

  localparam int unsigned CoreW = tile_cfg_pkg::CoreIdxWidth;
  localparam logic [CoreW-1:0] CoreBits = CoreW'(CoreIdx);

  typedef struct packed {
    tcdm_pkg::addr_t addr;
    logic            wen;
    tcdm_pkg::data_t wdata;
    tcdm_pkg::be_t   be;
  } entry_t;

  entry_t     swz;
  entry_t     entry_q [2];
  logic [1:0] vld_q;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic       push;
  logic       pop;

  // Network order, LSB first: byte, core, tile, bank, row
  assign swz.addr  = tcdm_pkg::addr_t'({
                       req_i.addr[tile_cfg_pkg::RowLsb +: tile_cfg_pkg::RowWidth],
                       req_i.addr[tile_cfg_pkg::BankLsb +: tile_cfg_pkg::BankIdxWidth],
                       req_i.addr[tile_cfg_pkg::TileLsb +: tile_cfg_pkg::TileIdxWidth],
                       CoreBits,
                       req_i.addr[tile_cfg_pkg::ByteOffset-1:0]});
  assign swz.wen   = req_i.wen;
  assign swz.wdata = req_i.wdata;
  assign swz.be    = req_i.be;

  assign req_i.gnt = !(vld_q[0] && vld_q[1]);
  assign push      = req_i.req && req_i.gnt;
  assign pop       = tcdm_master_req_o && tcdm_master_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= !wr_ptr_q;
      end
      if (pop) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= !rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= swz;
    end
  end

  assign tcdm_master_req_o   = vld_q[rd_ptr_q];
  assign tcdm_master_addr_o  = entry_q[rd_ptr_q].addr;
  assign tcdm_master_wen_o   = entry_q[rd_ptr_q].wen;
  assign tcdm_master_wdata_o = entry_q[rd_ptr_q].wdata;
  assign tcdm_master_be_o    = entry_q[rd_ptr_q].be;

  // Responses come straight back
  assign req_i.vld   = tcdm_master_vld_i;
  assign req_i.rdata = tcdm_master_rdata_i;

endmodule

/* design/core_demux.sv */
// ==================================================
// Per-core local/remote routing with read ordering
// ==================================================
module core_demux (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [tile_cfg_pkg::TileIdxWidth-1:0] tile_id_i,
  input  logic                                  core_req_i,
  input  tcdm_pkg::addr_t                       core_addr_i,
  input  logic                                  core_wen_i,
  input  tcdm_pkg::data_t                       core_wdata_i,
  input  tcdm_pkg::be_t                         core_be_i,
  output logic                                  core_gnt_o,
  output logic                                  core_vld_o,
  output tcdm_pkg::data_t                       core_rdata_o,
  tcdm_port_if.initiator                        local_o,
  tcdm_port_if.initiator                        remote_o
);

  localparam int unsigned TileLsb = tile_cfg_pkg::TileLsb;
  localparam int unsigned TileMsb = TileLsb + tile_cfg_pkg::TileIdxWidth - 1;

  tcdm_pkg::target_e tgt;
  tcdm_pkg::target_e pend_tgt_q;
  logic [1:0]        rd_cnt_q;
  logic              stall;
  logic              rd_issue;

  assign tgt = (core_addr_i[TileMsb:TileLsb] == tile_id_i) ? tcdm_pkg::TARGET_LOCAL
                                                            : tcdm_pkg::TARGET_REMOTE;

  // Two reads in flight at most, and never to both targets at once
  assign stall = (rd_cnt_q == 2'd2) || ((rd_cnt_q != 2'd0) && (pend_tgt_q != tgt));

  assign local_o.req   = core_req_i && !stall && (tgt == tcdm_pkg::TARGET_LOCAL);
  // Tile field dropped, row moves down next to the bank field
  assign local_o.addr  = tcdm_pkg::addr_t'({core_addr_i[tcdm_pkg::AddrWidth-1:TileMsb+1],
                                            core_addr_i[TileLsb-1:0]});
  assign local_o.wen   = core_wen_i;
  assign local_o.wdata = core_wdata_i;
  assign local_o.be    = core_be_i;

  assign remote_o.req   = core_req_i && !stall && (tgt == tcdm_pkg::TARGET_REMOTE);
  assign remote_o.addr  = core_addr_i;
  assign remote_o.wen   = core_wen_i;
  assign remote_o.wdata = core_wdata_i;
  assign remote_o.be    = core_be_i;

  assign core_gnt_o   = (local_o.req && local_o.gnt) || (remote_o.req && remote_o.gnt);
  assign core_vld_o   = local_o.vld || remote_o.vld;
  assign core_rdata_o = local_o.vld ? local_o.rdata : remote_o.rdata;

  assign rd_issue = core_gnt_o && !core_wen_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_cnt_q   <= 2'd0;
      pend_tgt_q <= tcdm_pkg::TARGET_LOCAL;
    end else begin
      if (rd_issue && !core_vld_o) begin
        rd_cnt_q <= rd_cnt_q + 2'd1;
      end else if (!rd_issue && core_vld_o) begin
        rd_cnt_q <= rd_cnt_q - 2'd1;
      end
      if (rd_issue) begin
        pend_tgt_q <= tgt;
      end
    end
  end

endmodule

/* design/tcdm_bank.sv */
// ==================================================
// Word-wide SRAM bank with byte enables
// ==================================================
module tcdm_bank (
  input  logic                clk_i,
  input  logic                req_i,
  input  logic                we_i,
  input  tcdm_pkg::bank_row_t addr_i,
  input  tcdm_pkg::data_t     wdata_i,
  input  tcdm_pkg::be_t       be_i,
  output tcdm_pkg::data_t     rdata_o
);

  tcdm_pkg::data_t mem_q [2**tile_cfg_pkg::RowWidth];
  tcdm_pkg::data_t bit_mask;

  for (genvar i = 0; i < tcdm_pkg::BeWidth; i++) begin : gen_mask
    assign bit_mask[8*i +: 8] = {8{be_i[i]}};
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= (mem_q[addr_i] & ~bit_mask) | (wdata_i & bit_mask);
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* design/tcdm_port_if.sv */
// ==================================================
// One TCDM request/response port
// ==================================================
interface tcdm_port_if;

  logic            req;
  tcdm_pkg::addr_t addr;
  logic            wen;
  tcdm_pkg::data_t wdata;
  tcdm_pkg::be_t   be;
  logic            gnt;
  logic            vld;
  tcdm_pkg::data_t rdata;

  modport initiator (
    output req, addr, wen, wdata, be,
    input  gnt, vld, rdata
  );

  modport target (
    input  req, addr, wen, wdata, be,
    output gnt, vld, rdata
  );

endinterface

/* design/tcdm_pkg.sv */
// ==================================================
// TCDM word, strobe and address types
// ==================================================
package tcdm_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned AddrWidth = 32;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;
  typedef logic [AddrWidth-1:0] addr_t;

  // Word address inside a tile, row above bank
  typedef logic [tile_cfg_pkg::RowWidth+tile_cfg_pkg::BankIdxWidth-1:0] tile_addr_t;
  // System-wide requester ID, tile above core
  typedef logic [tile_cfg_pkg::TileIdxWidth+tile_cfg_pkg::CoreIdxWidth-1:0] core_addr_t;
  typedef logic [tile_cfg_pkg::RowWidth-1:0] bank_row_t;

  typedef enum logic {
    TARGET_LOCAL,
    TARGET_REMOTE
  } target_e;

endpackage

/* design/tile_cfg_pkg.sv */
// ==================================================
// Tile geometry and address field positions
// ==================================================
package tile_cfg_pkg;

  localparam int unsigned NumCoresPerTile = 2;
  localparam int unsigned NumBanksPerTile = 4;
  localparam int unsigned NumTiles        = 4;

  // Field widths
  localparam int unsigned ByteOffset   = 2;
  localparam int unsigned BankIdxWidth = $clog2(NumBanksPerTile);
  localparam int unsigned TileIdxWidth = $clog2(NumTiles);
  localparam int unsigned CoreIdxWidth = $clog2(NumCoresPerTile);
  localparam int unsigned RowWidth     = 6;

  // Core address layout, LSB first: byte, bank, tile, row
  localparam int unsigned BankLsb = ByteOffset;
  localparam int unsigned TileLsb = BankLsb + BankIdxWidth;
  localparam int unsigned RowLsb  = TileLsb + TileIdxWidth;

endpackage
